//--- testbench/fetch_prog_testdata.hex
// one 32-bit instruction word per line, in hex
// @ records give the word index counted from the user text base 0x3000
@000
3c081234
35085678
24090004
01095021
11090003
00000000
2129ffff
0800c00a
ac0a0100
8c0b0100
01600008
00000000
1509fff8
3c0d00ff
42000018
0000000c
// last user word at 0x417c, where fetch parks
@45f
1000ffff
// kernel handler from 0x4180
@460
401a6800
401b7000
275b0004
409b7000
42000018
00000000
@461
401b7000
@466
3c1a8000
035a0021
@468
0000000d

//--- testbench/fetch_testdata.txt
# one vector per cycle, all fields hex, driven on the falling clock edge
# columns: stall clr stallPc instr cmp jmpReg kCtrl epc expPc
# kCtrl 0 none, 1 ktext, 2 eret; epc is the word address, expPc is pcIf after the edge
0 0 0 00000000 0 00000000 0 00000000 00003004
0 0 0 00000000 0 00000000 0 00000000 00003008
0 0 0 00000000 0 00000000 0 00000000 0000300c
0 0 0 11090003 1 00000000 0 00000000 00003018
0 0 0 11090003 0 00000000 0 00000000 0000301c
0 0 0 1509fffc 1 00000000 0 00000000 0000300c
0 0 0 00000000 0 00000000 0 00000000 00003010
0 0 0 08000c0c 0 00000000 0 00000000 00003030
0 0 0 0c000c05 0 00000000 0 00000000 00003014
0 0 0 01600008 0 00003020 0 00000000 00003020
0 0 0 0160f809 0 00003008 0 00000000 00003008
0 0 0 00000000 0 00000000 0 00000000 0000300c
# stalls and flushes
0 0 1 00000000 0 00000000 0 00000000 0000300c
0 0 1 08000c0c 0 00000000 0 00000000 0000300c
1 0 0 00000000 0 00000000 0 00000000 00003010
1 0 0 00000000 0 00000000 0 00000000 00003014
1 1 0 00000000 0 00000000 0 00000000 00003018
0 1 0 00000000 0 00000000 0 00000000 0000301c
0 0 0 00000000 0 00000000 0 00000000 00003020
1 0 1 00000000 0 00000000 0 00000000 00003020
# kernel entry and return
0 0 0 11090003 1 00000000 1 00000000 00004180
0 0 0 00000000 0 00000000 0 00000000 00004184
0 0 0 00000000 0 00000000 0 00000000 00004188
0 0 0 00000000 0 00000000 0 00000000 0000418c
0 0 0 01600008 0 00003000 2 00000c09 00003024
0 0 0 00000000 0 00000000 0 00000000 00003028
0 0 0 04110002 1 00000000 0 00000000 00003030
# out of the memory window and back
0 0 0 01600008 0 00008000 0 00000000 00008000
0 0 0 00000000 0 00000000 0 00000000 00008004
0 0 0 00000000 0 00000000 0 00000000 00008008
0 0 0 01600008 0 00003030 0 00000000 00003030
0 0 0 00000000 0 00000000 0 00000000 00003034
0 0 0 00000000 0 00000000 0 00000000 00003038
# program end and terminal hold
0 0 0 0800105f 0 00000000 0 00000000 0000417c
0 0 0 00000000 0 00000000 0 00000000 0000417c
0 0 0 08000c00 0 00000000 0 00000000 0000417c
0 0 0 00000000 0 00000000 1 00000000 0000417c
0 0 0 00000000 0 00000000 2 00000c00 0000417c
0 0 0 01600008 0 00003000 0 00000000 0000417c

//--- flist.f
verilog/memMapPkg.sv
verilog/isaPkg.sv
verilog/instrClassifier.sv
verilog/nextPcSelect.sv
verilog/instrMemory.sv
verilog/fetchStage.sv
testbench/fetchStage_properties.sv
testbench/fetchStage_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the fetch stage testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module fetchStage_tb \
    -f flist.f

# a failing run still has its log searched below
./obj_dir/VfetchStage_tb > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Simulation finished: PASS" "$LOG"; then
    exit 0
fi

echo "no pass reported by the testbench, see $LOG"
exit 1

//--- testbench/fetchStage_tb.sv
`timescale 1ns/10ps
`default_nettype none

module fetchStage_tb;
    import memMapPkg::*;
    import isaPkg::*;

    localparam int CLK_HALF = 20;
    localparam int MAX_LINES = 256;
    localparam int RUN_LIMIT_CYCLES = 400;
    localparam int END_WAIT_CYCLES = 8;
    localparam string VECTOR_FILE = "testbench/fetch_testdata.txt";

    // one line of the vector file
    typedef struct packed {
        logic stall;
        logic clr;
        logic stallPc;
        branchInfoT branchInfo;
        cp0RedirectT cp0Redirect;
        pcT expPc;
    } vectorT;

    logic clk;
    logic reset;
    logic stall;
    logic clr;
    logic stallPc;
    branchInfoT branchInfo;
    cp0RedirectT cp0Redirect;
    ifIdT ifId;
    pcT pcIf;

    vectorT vectors[$];
    instrT imageMem [IM_WORDS];
    pcT modelPc;
    ifIdT modelIfId;
    int pcErrors;
    int ifIdErrors;
    int otherErrors;

    fetchStage u_dut (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .clr(clr),
        .stallPc(stallPc),
        .branchInfo(branchInfo),
        .cp0Redirect(cp0Redirect),
        .ifId(ifId),
        .pcIf(pcIf)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #CLK_HALF clk = ~clk;
        end
    end

    task automatic loadVectors();
        int fd;
        int lineCount;
        int fieldCount;
        string line;
        logic [31:0] fld [9];
        vectorT vec;
        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            $display("could not open the vector file %s", VECTOR_FILE);
            otherErrors++;
            return;
        end
        lineCount = 0;
        while (lineCount < MAX_LINES && $fgets(line, fd) != 0) begin
            lineCount++;
            // comment lines give no fields
            fieldCount = $sscanf(line, "%h %h %h %h %h %h %h %h %h", fld[0], fld[1],
                fld[2], fld[3], fld[4], fld[5], fld[6], fld[7], fld[8]);
            if (fieldCount == 9) begin
                vec.stall = fld[0][0];
                vec.clr = fld[1][0];
                vec.stallPc = fld[2][0];
                vec.branchInfo.instr = fld[3];
                vec.branchInfo.cmp = fld[4][0];
                vec.branchInfo.jmpReg = fld[5];
                vec.cp0Redirect.kCtrl = kCtrlE'(fld[6][1:0]);
                vec.cp0Redirect.epc = fld[7][29:0];
                vec.expPc = fld[8];
                vectors.push_back(vec);
            end
        end
        $fclose(fd);
        if (vectors.size() == 0) begin
            $display("the vector file %s holds no vectors", VECTOR_FILE);
            otherErrors++;
        end
    endtask

    task automatic loadImage();
        for (int i = 0; i < IM_WORDS; i++) begin
            imageMem[i] = '0;
        end
        $readmemh(IMAGE_FILE, imageMem);
    endtask

    // reference fetch: zero outside the text window
    function automatic instrT imageWord(input pcT addr);
        if (addr < TEXT_START || addr >= TEXT_START + IM_BYTES) begin
            return '0;
        end
        return imageMem[int'((addr - TEXT_START) >> 2)];
    endfunction

    task automatic checkPc(input string name, input pcT expected, input pcT actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            pcErrors++;
        end
    endtask

    task automatic checkIfId(input string name, input ifIdT expected, input ifIdT actual);
        if (actual !== expected) begin
            $display("** Error: %s expected code %h pc %h actual code %h pc %h", name,
                expected.code, expected.pc, actual.code, actual.pc);
            ifIdErrors++;
        end
    endtask

    // model update happens against the address presented before the edge
    task automatic applyVector(input vectorT vec);
        if (vec.clr) begin
            modelIfId = '0;
        end else if (!vec.stall) begin
            modelIfId.code = imageWord(modelPc);
            modelIfId.pc = modelPc;
        end
        modelPc = vec.expPc;
        stall = vec.stall;
        clr = vec.clr;
        stallPc = vec.stallPc;
        branchInfo = vec.branchInfo;
        cp0Redirect = vec.cp0Redirect;
    endtask

    task automatic finishRun(input bit timedOut);
        $display("pc errors %0d, ifId errors %0d, other errors %0d", pcErrors, ifIdErrors,
            otherErrors);
        if (!timedOut && pcErrors == 0 && ifIdErrors == 0 && otherErrors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    initial begin
        vectorT idleVec;
        reset = 1'b1;
        stall = 1'b0;
        clr = 1'b0;
        stallPc = 1'b0;
        branchInfo = '0;
        cp0Redirect = '0;
        pcErrors = 0;
        ifIdErrors = 0;
        otherErrors = 0;
        loadVectors();
        loadImage();
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        checkPc("reset pcIf", TEXT_START, pcIf);
        checkIfId("reset ifId", '0, ifId);
        modelPc = TEXT_START;
        modelIfId = '0;
        foreach (vectors[i]) begin
            applyVector(vectors[i]);
            @(negedge clk);
            checkPc($sformatf("vector %0d pcIf", i), modelPc, pcIf);
            checkIfId($sformatf("vector %0d ifId", i), modelIfId, ifId);
        end
        // idle inputs, fetch should stay parked at program end
        idleVec = '0;
        idleVec.expPc = TERMINAL_PC;
        for (int n = 0; n < END_WAIT_CYCLES; n++) begin
            applyVector(idleVec);
            @(negedge clk);
            checkPc($sformatf("idle %0d pcIf", n), modelPc, pcIf);
            checkIfId($sformatf("idle %0d ifId", n), modelIfId, ifId);
        end
        finishRun(1'b0);
    end

    initial begin
        #(RUN_LIMIT_CYCLES * 2 * CLK_HALF);
        $display("run limit of %0d cycles reached before the vectors finished",
            RUN_LIMIT_CYCLES);
        finishRun(1'b1);
    end

endmodule

`default_nettype wire

//--- testbench/fetchStage_properties.sv
`timescale 1ns/10ps
`default_nettype none

module fetchStage_properties (
    input logic           clk,
    input logic           reset,
    input logic           stall,
    input logic           clr,
    input logic           stallPc,
    input isaPkg::ifIdT   ifId,
    input memMapPkg::pcT  pcIf
);
    import memMapPkg::*;
    import isaPkg::*;

    // program counter frozen by stallPc
    pcHold: assert property (@(posedge clk) (!reset && stallPc) |=> $stable(pcIf))
        else $error("pcIf changed after an edge with stallPc high");

    // flush lands a bubble
    ifIdFlush: assert property (@(posedge clk) clr |=> (ifId == '0))
        else $error("ifId not zero after an edge with clr high");

    // stall without flush keeps the IF/ID contents
    ifIdHold: assert property (@(posedge clk) (!reset && stall && !clr) |=> $stable(ifId))
        else $error("ifId changed after an edge with stall high and clr low");

    pcReset: assert property (@(posedge clk) reset |=> (pcIf == TEXT_START))
        else $error("pcIf not at the text base after reset");

endmodule

bind fetchStage fetchStage_properties u_props (
    .clk(clk),
    .reset(reset),
    .stall(stall),
    .clr(clr),
    .stallPc(stallPc),
    .ifId(ifId),
    .pcIf(pcIf)
);

`default_nettype wire

//--- verilog/fetchStage.sv
`timescale 1ns/10ps
`default_nettype none

module fetchStage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall,
    input  logic                 clr,
    input  logic                 stallPc,
    input  isaPkg::branchInfoT   branchInfo,
    input  isaPkg::cp0RedirectT  cp0Redirect,
    output isaPkg::ifIdT         ifId,
    output memMapPkg::pcT        pcIf
);
    import memMapPkg::*;
    import isaPkg::*;

    pcT nextPc;
    instrT fetchCode;

    // next fetch address, purely combinational
    nextPcSelect u_nextPc (
        .pc(pcIf),
        .branchInfo(branchInfo),
        .cp0Redirect(cp0Redirect),
        .nextPc(nextPc)
    );

    // code word at the current fetch address
    instrMemory u_imem (
        .pc(pcIf),
        .code(fetchCode)
    );

    // program counter, held while hazard logic asserts stallPc
    always_ff @(posedge clk) begin
        if (reset) begin
            pcIf <= TEXT_START;
        end else if (!stallPc) begin
            pcIf <= nextPc;
        end
    end

    // IF/ID register
    // flush beats stall, so a bubble lands even in a frozen stage
    always_ff @(posedge clk) begin
        if (reset || clr) begin
            ifId <= '0;
        end else if (!stall) begin
            ifId.code <= fetchCode;
            ifId.pc <= pcIf;
        end
    end

endmodule

`default_nettype wire

//--- verilog/instrMemory.sv
`timescale 1ns/10ps
`default_nettype none

module instrMemory (
    input  memMapPkg::pcT pc,
    output isaPkg::instrT code
);
    import memMapPkg::*;
    import isaPkg::*;

    instrT mem [IM_WORDS];
    pcT offset;
    logic [IM_INDEX_W-1:0] wordIndex;
    logic inWindow;

    // words not named in the image read back as zero
    initial begin
        for (int i = 0; i < IM_WORDS; i++) begin
            mem[i] = '0;
        end
        $readmemh(IMAGE_FILE, mem);
    end

    // byte offset from the text base, then word index
    assign offset = pc - TEXT_START;
    assign wordIndex = offset[IM_INDEX_W+1:2];

    assign inWindow = (pc >= TEXT_START) && (pc < TEXT_START + IM_BYTES);

    // outside the memory window the fetch sees a nop
    assign code = inWindow ? mem[wordIndex] : '0;

endmodule

`default_nettype wire

//--- verilog/nextPcSelect.sv
`timescale 1ns/10ps
`default_nettype none

module nextPcSelect (
    input  memMapPkg::pcT        pc,
    input  isaPkg::branchInfoT   branchInfo,
    input  isaPkg::cp0RedirectT  cp0Redirect,
    output memMapPkg::pcT        nextPc
);
    import memMapPkg::*;
    import isaPkg::*;

    instrClassE instrClass;
    logic [15:0] imm16;
    logic [25:0] jumpIndex;
    pcT branchOffset;
    pcT seqPc;
    pcT branchPc;
    pcT jumpImmPc;
    pcT eretPc;
    logic terminated;

    instrClassifier u_classifier (
        .instr(branchInfo.instr),
        .instrClass(instrClass)
    );

    // immediate fields come straight from the decode instruction
    assign imm16 = branchInfo.instr[IMM_MSB:IMM_LSB];
    assign jumpIndex = branchInfo.instr[JIDX_MSB:JIDX_LSB];

    assign branchOffset = {{14{imm16[15]}}, imm16, 2'b00};
    assign seqPc = pc + 32'd4;
    assign branchPc = pc + branchOffset;
    assign jumpImmPc = {pc[31:28], jumpIndex, 2'b00};
    assign eretPc = {cp0Redirect.epc, 2'b00};

    // program end, fetch parks on the word below the handler
    assign terminated = (pc == TERMINAL_PC);

    always_comb begin
        if (terminated) begin
            nextPc = pc;
        end else if (cp0Redirect.kCtrl == KCTRL_KTEXT) begin
            nextPc = KTEXT_START;
        end else if (cp0Redirect.kCtrl == KCTRL_ERET) begin
            nextPc = eretPc;
        end else begin
            case (instrClass)
                // not-taken branch falls through to sequential
                CLASS_BRANCH: nextPc = branchInfo.cmp ? branchPc : seqPc;
                CLASS_JUMP_IMM: nextPc = jumpImmPc;
                CLASS_JUMP_REG: nextPc = branchInfo.jmpReg;
                default: nextPc = seqPc;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/instrClassifier.sv
`timescale 1ns/10ps
`default_nettype none

module instrClassifier (
    input  isaPkg::instrT      instr,
    output isaPkg::instrClassE instrClass
);
    import isaPkg::*;

    opcodeT opcode;
    functT funct;
    logic isRegJump;
    logic isImmJump;
    logic isBranch;

    assign opcode = instr[OPCODE_MSB:OPCODE_LSB];
    assign funct = instr[FUNCT_MSB:FUNCT_LSB];

    // jr and jalr only count under the SPECIAL opcode
    always_comb begin
        isRegJump = 1'b0;
        if (opcode == OP_SPECIAL) begin
            isRegJump = (funct == FN_JR) || (funct == FN_JALR);
        end
    end

    assign isImmJump = (opcode == OP_J) || (opcode == OP_JAL);

    // regimm covers bltz/bgez and friends
    always_comb begin
        case (opcode)
            OP_BEQ,
            OP_BNE,
            OP_BLEZ,
            OP_BGTZ,
            OP_REGIMM: isBranch = 1'b1;
            default: isBranch = 1'b0;
        endcase
    end

    // classes are mutually exclusive by opcode, order is cosmetic
    always_comb begin
        if (isRegJump) begin
            instrClass = CLASS_JUMP_REG;
        end else if (isImmJump) begin
            instrClass = CLASS_JUMP_IMM;
        end else if (isBranch) begin
            instrClass = CLASS_BRANCH;
        end else begin
            instrClass = CLASS_SEQ;
        end
    end

endmodule

`default_nettype wire

//--- verilog/isaPkg.sv
`default_nettype none

package isaPkg;

    typedef logic [31:0] instrT;
    typedef logic [5:0] opcodeT;
    typedef logic [5:0] functT;

    // field positions in the instruction word
    localparam int OPCODE_MSB = 31;
    localparam int OPCODE_LSB = 26;
    localparam int FUNCT_MSB = 5;
    localparam int FUNCT_LSB = 0;
    localparam int IMM_MSB = 15;
    localparam int IMM_LSB = 0;
    localparam int JIDX_MSB = 25;
    localparam int JIDX_LSB = 0;

    // primary opcodes
    localparam opcodeT OP_SPECIAL = 6'h00;
    localparam opcodeT OP_REGIMM = 6'h01;
    localparam opcodeT OP_J = 6'h02;
    localparam opcodeT OP_JAL = 6'h03;
    localparam opcodeT OP_BEQ = 6'h04;
    localparam opcodeT OP_BNE = 6'h05;
    localparam opcodeT OP_BLEZ = 6'h06;
    localparam opcodeT OP_BGTZ = 6'h07;

    // function codes under SPECIAL
    localparam functT FN_JR = 6'h08;
    localparam functT FN_JALR = 6'h09;

    // control-flow class of the instruction in decode
    typedef enum logic [1:0] {
        CLASS_SEQ = 2'd0,
        CLASS_BRANCH = 2'd1,
        CLASS_JUMP_IMM = 2'd2,
        CLASS_JUMP_REG = 2'd3
    } instrClassE;

    // redirect request from the exception logic
    typedef enum logic [1:0] {
        KCTRL_NONE = 2'd0,
        KCTRL_KTEXT = 2'd1,
        KCTRL_ERET = 2'd2
    } kCtrlE;

    // decode-stage results feeding the next address
    typedef struct packed {
        instrT instr;
        logic cmp;
        logic [31:0] jmpReg;
    } branchInfoT;

    // epc keeps only the word-aligned upper bits
    typedef struct packed {
        kCtrlE kCtrl;
        logic [29:0] epc;
    } cp0RedirectT;

    // IF/ID pipeline register contents
    typedef struct packed {
        instrT code;
        logic [31:0] pc;
    } ifIdT;

endpackage

`default_nettype wire

//--- verilog/memMapPkg.sv
`default_nettype none

package memMapPkg;

    // byte address, one word wide
    typedef logic [31:0] pcT;

    // user text and kernel handler regions
    localparam pcT TEXT_START = 32'h0000_3000;
    localparam pcT KTEXT_START = 32'h0000_4180;
    localparam pcT KTEXT_END = 32'h0000_4FFC;

    // instruction memory geometry
    localparam int IM_WORDS = 4096;
    localparam int IM_INDEX_W = 12;
    localparam pcT IM_BYTES = pcT'(IM_WORDS * 4);

    // hex image, relative to the simulation directory
    // handler words sit at their kernel offset via @ records
    localparam string IMAGE_FILE = "testbench/fetch_prog_testdata.hex";

    // last user word; fetch parks here at program end
    localparam pcT TERMINAL_PC = KTEXT_START - 32'd4;

endpackage

`default_nettype wire
